// ==== logic/upd78_pkg.sv ====
// uPD7800 subset definitions
`default_nettype none

package upd78_pkg;

  // Clock phases per machine cycle
  localparam int PHASES = 4;
  localparam int PHASE_W = $clog2(PHASES);

  // Program and data memory
  localparam int MEM_DEPTH = 256;
  localparam int MEM_AW = $clog2(MEM_DEPTH);

  localparam logic [15:0] RESET_PC = 16'h0000;

  // Group codes; register forms carry the register number in bits 2:0
  typedef enum logic [7:0] {
    OP_NOP     = 8'h00,
    OP_HALT    = 8'h01,
    OP_ANI     = 8'h07,
    OP_MOV_A_R = 8'h08,
    OP_XRI     = 8'h16,
    OP_ORI     = 8'h17,
    OP_MOV_R_A = 8'h18,
    OP_STAX    = 8'h3B,
    OP_INR     = 8'h40,
    OP_ADI     = 8'h46,
    OP_SKC     = 8'h48,
    OP_SKNC    = 8'h49,
    OP_SKZ     = 8'h4A,
    OP_SKNZ    = 8'h4B,
    OP_DCR     = 8'h50,
    OP_ACI     = 8'h56,
    OP_DAA     = 8'h61,
    OP_SUI     = 8'h66,
    OP_MVI     = 8'h68,
    OP_JR      = 8'hC0
  } e_opcode;

  typedef enum logic [2:0] {
    ST_RESET, ST_FETCH, ST_OPERAND, ST_EXEC, ST_STORE, ST_HALT
  } e_state;

  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_INC, ALU_DEC, ALU_DAA
  } e_alu_op;

  // Same order as the low opcode bits
  typedef enum logic [2:0] {
    RS_V, RS_A, RS_B, RS_C, RS_D, RS_E, RS_H, RS_L
  } e_reg_sel;

endpackage

`default_nettype wire

// ==== logic/phase_gen.sv ====
// Machine cycle phase strobes
`timescale 1ns/1ps
`default_nettype none

module phase_gen (
  input  logic CLK,
  input  logic rst_n,
  output logic cp1_rise,
  output logic cp1_fall,
  output logic cp2_rise,
  output logic cp2_fall
);
  import upd78_pkg::*;

  logic [PHASE_W-1:0] phase;

  // Counter restarts at zero, so cp1_rise leads after reset release
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      phase    <= '0;
      cp1_rise <= 1'b0;
      cp1_fall <= 1'b0;
      cp2_rise <= 1'b0;
      cp2_fall <= 1'b0;
    end else begin
      phase    <= (phase == PHASE_W'(PHASES - 1)) ? '0 : phase + 1'b1;
      cp1_rise <= (phase == PHASE_W'(0));
      cp1_fall <= (phase == PHASE_W'(1));
      cp2_rise <= (phase == PHASE_W'(2));
      cp2_fall <= (phase == PHASE_W'(PHASES - 1));
    end
  end

endmodule

`default_nettype wire

// ==== logic/upd78_regs.sv ====
// General purpose register file
`timescale 1ns/1ps
`default_nettype none

module upd78_regs (
  input  logic                 CLK,
  input  logic                 rst_n,
  input  logic                 wr_en,
  input  upd78_pkg::e_reg_sel  wr_sel,
  input  logic [7:0]           wr_data,
  input  upd78_pkg::e_reg_sel  rd_sel,
  output logic [7:0]           rd_data,
  output logic [15:0]          hl,
  output logic [7:0]           acc
);
  import upd78_pkg::*;

  // V, A, B, C, D, E, H, L
  logic [7:0] rf [8];

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 8; i++) begin
        rf[i] <= 8'h00;
      end
    end else if (wr_en) begin
      rf[wr_sel] <= wr_data;
    end
  end

  assign rd_data = rf[rd_sel];
  assign acc     = rf[RS_A];

  // Pointer pair for STAX
  assign hl = {rf[RS_H], rf[RS_L]};

endmodule

`default_nettype wire

// ==== logic/upd78_alu.sv ====
// Byte ALU with decimal adjust
`timescale 1ns/1ps
`default_nettype none

module upd78_alu (
  input  upd78_pkg::e_alu_op op,
  input  logic [7:0]         a,
  input  logic [7:0]         b,
  input  logic               carry_in,
  input  logic               half_in,
  output logic [7:0]         result,
  output logic               carry,
  output logic               half,
  output logic               zero
);
  import upd78_pkg::*;

  always_comb begin
    logic [4:0] lsum;
    logic [4:0] hsum;
    logic [7:0] b_eff;
    logic       c_eff;
    logic       adj_lo;
    logic       adj_hi;

    adj_lo = (a[3:0] > 4'h9) | half_in;
    adj_hi = (a > 8'h99) | carry_in;
    b_eff  = b;
    c_eff  = carry_in;
    case (op)
      ALU_SUB: begin
        b_eff = ~b;
        c_eff = 1'b1;
      end
      ALU_INC: begin
        b_eff = 8'h00;
        c_eff = 1'b1;
      end
      ALU_DEC: begin
        b_eff = 8'hFF;
        c_eff = 1'b0;
      end
      ALU_DAA: begin
        b_eff = {adj_hi ? 4'h6 : 4'h0, adj_lo ? 4'h6 : 4'h0};
        c_eff = 1'b0;
      end
      default: ;
    endcase

    // Two nibble adders, half carry out of the low one
    lsum = {1'b0, a[3:0]} + {1'b0, b_eff[3:0]} + {4'b0, c_eff};
    hsum = {1'b0, a[7:4]} + {1'b0, b_eff[7:4]} + {4'b0, lsum[4]};

    result = {hsum[3:0], lsum[3:0]};
    carry  = hsum[4];
    half   = lsum[4];
    case (op)
      ALU_SUB, ALU_DEC: begin
        // Borrow sense
        carry = ~hsum[4];
        half  = ~lsum[4];
      end
      ALU_DAA: carry = adj_hi;
      ALU_AND: {result, carry, half} = {a & b, 2'b00};
      ALU_OR:  {result, carry, half} = {a | b, 2'b00};
      ALU_XOR: {result, carry, half} = {a ^ b, 2'b00};
      default: ;
    endcase
  end

  assign zero = (result == 8'h00);

endmodule

`default_nettype wire

// ==== logic/upd78_core.sv ====
// uPD7800 subset core
`timescale 1ns/1ps
`default_nettype none

module upd78_core (
  input  logic        CLK,
  input  logic        rst_n,
  input  logic        cp1_rise,
  input  logic        cp1_fall,
  input  logic        cp2_rise,
  input  logic        cp2_fall,
  input  logic [7:0]  din,
  output logic [15:0] addr,
  output logic [7:0]  dout,
  output logic        dout_en,
  output logic        m1,
  output logic        rdb,
  output logic        wrb,
  output logic        halted
);
  import upd78_pkg::*;

  e_state      state;
  e_opcode     op;
  e_opcode     op_fetch;
  e_alu_op     alu_op;
  e_reg_sel    rd_sel;
  e_reg_sel    wr_sel;
  logic [15:0] pc;
  logic [15:0] hl;
  logic [15:0] aor;
  logic [7:0]  ir;
  logic [7:0]  w;
  logic [7:0]  dor;
  logic [7:0]  idb;
  logic [7:0]  rd_data;
  logic [7:0]  acc;
  logic [7:0]  alu_a;
  logic [7:0]  alu_result;
  logic        alu_cin;
  logic        alu_carry;
  logic        alu_half;
  logic        alu_zero;
  logic        psw_z;
  logic        psw_sk;
  logic        psw_hc;
  logic        psw_cy;
  logic        skip_op;
  logic        wr_ext;
  logic        reg_upd;
  logic        reg_wr;
  logic        upd_z;
  logic        upd_hc;
  logic        upd_cy;

  function automatic e_opcode decode(input logic [7:0] code);
    e_opcode res;
    casez (code)
      8'b11??_????: res = OP_JR;
      8'b0110_1???: res = OP_MVI;
      8'b0000_1???: res = OP_MOV_A_R;
      8'b0001_1???: res = OP_MOV_R_A;
      8'b0100_00??: res = OP_INR;
      8'b0101_00??: res = OP_DCR;
      OP_HALT, OP_ANI, OP_XRI, OP_ORI, OP_STAX, OP_ADI, OP_SKC, OP_SKNC,
      OP_SKZ, OP_SKNZ, OP_ACI, OP_DAA, OP_SUI: res = e_opcode'(code);
      default: res = OP_NOP;
    endcase
    return res;
  endfunction

  // Two-byte instructions
  function automatic logic has_operand(input e_opcode o);
    return o inside {OP_MVI, OP_ADI, OP_ACI, OP_SUI, OP_ANI, OP_ORI, OP_XRI};
  endfunction

  assign op_fetch = decode(din);
  assign op       = decode(ir);
  assign rd_sel   = e_reg_sel'(ir[2:0]);

  upd78_regs u_regs (
    .CLK     (CLK),
    .rst_n   (rst_n),
    .wr_en   (reg_wr),
    .wr_sel  (wr_sel),
    .wr_data (idb),
    .rd_sel  (rd_sel),
    .rd_data (rd_data),
    .hl      (hl),
    .acc     (acc)
  );

  upd78_alu u_alu (
    .op       (alu_op),
    .a        (alu_a),
    .b        (w),
    .carry_in (alu_cin),
    .half_in  (psw_hc),
    .result   (alu_result),
    .carry    (alu_carry),
    .half     (alu_half),
    .zero     (alu_zero)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Execute decode

  always_comb begin
    alu_op  = ALU_ADD;
    alu_a   = acc;
    alu_cin = 1'b0;
    wr_sel  = RS_A;
    reg_upd = 1'b0;
    upd_z   = 1'b0;
    upd_hc  = 1'b0;
    upd_cy  = 1'b0;
    case (op)
      OP_MVI, OP_MOV_R_A: begin
        wr_sel  = rd_sel;
        reg_upd = 1'b1;
      end
      OP_MOV_A_R: reg_upd = 1'b1;
      OP_ADI, OP_ACI, OP_SUI, OP_DAA: begin
        alu_op  = (op == OP_SUI) ? ALU_SUB : (op == OP_DAA) ? ALU_DAA : ALU_ADD;
        alu_cin = (op == OP_ACI || op == OP_DAA) ? psw_cy : 1'b0;
        reg_upd = 1'b1;
        {upd_z, upd_hc, upd_cy} = 3'b111;
      end
      OP_ANI, OP_ORI, OP_XRI: begin
        alu_op  = (op == OP_ANI) ? ALU_AND : (op == OP_ORI) ? ALU_OR : ALU_XOR;
        reg_upd = 1'b1;
        upd_z   = 1'b1;
      end
      OP_INR, OP_DCR: begin
        // Carry is left alone
        alu_op  = (op == OP_INR) ? ALU_INC : ALU_DEC;
        alu_a   = rd_data;
        wr_sel  = rd_sel;
        reg_upd = 1'b1;
        upd_z   = 1'b1;
        upd_hc  = 1'b1;
      end
      default: ;
    endcase
  end

  // Internal data bus
  always_comb begin
    case (op)
      OP_MVI:     idb = w;
      OP_MOV_A_R: idb = rd_data;
      OP_MOV_R_A: idb = acc;
      OP_JR:      idb = {{2{ir[5]}}, ir[5:0]};
      default:    idb = alu_result;
    endcase
  end

  assign reg_wr = cp2_fall & (state == ST_EXEC) & reg_upd;

  ////////////////////////////////////////////////////////////////////////////
  // Sequencer, PC and PSW

  // The reset cycle keeps the bus idle until the first cp2_fall
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      state   <= ST_RESET;
      pc      <= RESET_PC;
      psw_z   <= 1'b0;
      psw_sk  <= 1'b0;
      psw_hc  <= 1'b0;
      psw_cy  <= 1'b0;
      skip_op <= 1'b0;
    end else if (cp2_fall) begin
      case (state)
        ST_RESET: state <= ST_FETCH;
        ST_FETCH: begin
          pc      <= pc + 16'd1;
          psw_sk  <= 1'b0;
          skip_op <= psw_sk;
          if (has_operand(op_fetch)) begin
            state <= ST_OPERAND;
          end else begin
            state <= psw_sk ? ST_FETCH : ST_EXEC;
          end
        end
        ST_OPERAND: begin
          pc    <= pc + 16'd1;
          state <= skip_op ? ST_FETCH : ST_EXEC;
        end
        ST_EXEC: begin
          case (op)
            OP_SKC:  psw_sk <= psw_cy;
            OP_SKNC: psw_sk <= ~psw_cy;
            OP_SKZ:  psw_sk <= psw_z;
            OP_SKNZ: psw_sk <= ~psw_z;
            // PC already points past the JR byte
            OP_JR:   pc <= pc + {{8{idb[7]}}, idb};
            default: ;
          endcase
          if (upd_z) begin
            psw_z <= alu_zero;
          end
          if (upd_hc) begin
            psw_hc <= alu_half;
          end
          if (upd_cy) begin
            psw_cy <= alu_carry;
          end
          if (op == OP_STAX) begin
            state <= ST_STORE;
          end else if (op == OP_HALT) begin
            state <= ST_HALT;
          end else begin
            state <= ST_FETCH;
          end
        end
        ST_STORE: state <= ST_FETCH;
        default:  state <= ST_HALT;
      endcase
    end
  end

  // Opcode and operand bytes
  always_ff @(posedge CLK) begin
    if (cp2_fall) begin
      if (state == ST_FETCH) begin
        ir <= din;
      end
      if (state == ST_OPERAND) begin
        w <= din;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // External bus

  always_ff @(posedge CLK) begin
    if (cp1_rise) begin
      if (state == ST_FETCH || state == ST_OPERAND) begin
        aor <= pc;
      end else if (state == ST_STORE) begin
        aor <= hl;
      end
      if (state == ST_STORE) begin
        dor <= acc;
      end
    end
  end

  // WRB from cp1 rise of the store cycle to the next cp2 rise
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      m1     <= 1'b0;
      rdb    <= 1'b1;
      wr_ext <= 1'b0;
    end else begin
      if (cp1_rise) begin
        m1 <= (state == ST_FETCH);
        if (state == ST_STORE) begin
          wr_ext <= 1'b1;
        end
      end else if (cp2_rise) begin
        wr_ext <= 1'b0;
      end
      if (cp1_fall) begin
        rdb <= ~(state == ST_FETCH || state == ST_OPERAND);
      end else if (cp2_fall) begin
        rdb <= 1'b1;
      end
    end
  end

  assign addr    = aor;
  assign dout    = dor;
  assign wrb     = ~wr_ext;
  assign dout_en = wr_ext;
  assign halted  = (state == ST_HALT);

endmodule

`default_nettype wire

// ==== logic/bus_memory.sv ====
// Program and data memory
`timescale 1ns/1ps
`default_nettype none

module bus_memory (
  input  logic        CLK,
  input  logic [15:0] addr,
  input  logic [7:0]  wr_data,
  input  logic        wrb,
  input  logic        wr_strobe,
  output logic [7:0]  rd_data
);
  import upd78_pkg::*;

  logic [7:0] mem [MEM_DEPTH];

  // Only the low address bits decode
  logic [MEM_AW-1:0] index;

  assign index = addr[MEM_AW-1:0];

  initial begin
    $readmemh("program.mem", mem);
  end

  // One write per store cycle
  always_ff @(posedge CLK) begin
    if (!wrb && wr_strobe) begin
      mem[index] <= wr_data;
    end
  end

  assign rd_data = mem[index];

endmodule

`default_nettype wire

// ==== logic/upd78_system.sv ====
// uPD7800 subset system
`timescale 1ns/1ps
`default_nettype none

module upd78_system (
  input  logic        CLK,
  input  logic        rst_n,
  output logic [15:0] addr,
  output logic [7:0]  dout,
  output logic        m1,
  output logic        rdb,
  output logic        wrb,
  output logic        halted
);

  logic       cp1_rise;
  logic       cp1_fall;
  logic       cp2_rise;
  logic       cp2_fall;
  logic [7:0] din;

  phase_gen u_phase (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .cp1_rise (cp1_rise),
    .cp1_fall (cp1_fall),
    .cp2_rise (cp2_rise),
    .cp2_fall (cp2_fall)
  );

  upd78_core u_core (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .cp1_rise (cp1_rise),
    .cp1_fall (cp1_fall),
    .cp2_rise (cp2_rise),
    .cp2_fall (cp2_fall),
    .din      (din),
    .addr     (addr),
    .dout     (dout),
    .dout_en  (),
    .m1       (m1),
    .rdb      (rdb),
    .wrb      (wrb),
    .halted   (halted)
  );

  // Writes land on cp2_rise while WRB is low
  bus_memory u_mem (
    .CLK       (CLK),
    .addr      (addr),
    .wr_data   (dout),
    .wrb       (wrb),
    .wr_strobe (cp2_rise),
    .rd_data   (din)
  );

endmodule

`default_nettype wire

// ==== test/tb_upd78_system.sv ====
// Store-checking testbench for the uPD7800 subset system
`timescale 1ns/1ps
`default_nettype none

module tb_upd78_system;
  import upd78_pkg::*;

  localparam int          CLK_HALF    = 10;
  localparam int          DRIVE_DELAY = 2;
  localparam int          RESET_LEN   = 5;
  localparam logic [31:0] SEED        = 32'h449a;

  logic        CLK;
  logic        rst_n;
  logic [15:0] addr;
  logic [7:0]  dout;
  logic        m1;
  logic        rdb;
  logic        wrb;
  logic        halted;

  // One entry per store the program is expected to make
  logic [15:0] exp_addr [$];
  logic [7:0]  exp_data [$];
  string       exp_name [$];

  int next_idx = 0;
  int passed   = 0;
  int errors   = 0;

  upd78_system UUT (
    .CLK    (CLK),
    .rst_n  (rst_n),
    .addr   (addr),
    .dout   (dout),
    .m1     (m1),
    .rdb    (rdb),
    .wrb    (wrb),
    .halted (halted)
  );

  initial begin
    CLK = 1'b0;
    forever #CLK_HALF CLK = ~CLK;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Expected stores

  task automatic add_expect(input logic [15:0] a, input logic [7:0] d, input string n);
    exp_addr.push_back(a);
    exp_data.push_back(d);
    exp_name.push_back(n);
  endtask

  // Values follow from the ALU and skip rules, in program order
  // ADI 20 + F0 = 110 leaves 10 with CY set so SKC skips the E7 marker
  // ACI 05 + 10 + 1 = 16 clears CY and the C2 marker reaches E9
  // SUI 10 - 20 = F0 borrows so SKC skips the EB marker
  // INR FF wraps to 00 and sets Z, SKZ skips ED, CY still set lets EE through
  // DCR B from 00 gives FF with Z clear so the F0 marker is stored
  // XRI A5 with A5 gives 00 and Z, so SKNZ falls through to F4
  // DAA 7D has low nibble above 9, adds 06 for 83
  // DAA 9A adjusts both nibbles, 9A + 66 = 100 gives 00 and CY
  // Two true SKC tests drop a STAX and an MVI A,EE, so F8 keeps D0
  // JR +1 at A9 lands on AB past the STAX, JR -5 at B8 returns to B4
  task automatic build_table();
    add_expect(16'h00E0, 8'h11, "mov_a_b");
    add_expect(16'h00E1, 8'h22, "mov_a_c");
    add_expect(16'h00E2, 8'h33, "mov_a_d");
    add_expect(16'h00E3, 8'h44, "mov_a_e");
    add_expect(16'h00E4, 8'h55, "mov_a_h");
    add_expect(16'h00E5, 8'h66, "mov_a_l");
    add_expect(16'h00E6, 8'h10, "adi_carry");
    add_expect(16'h00E8, 8'h16, "aci_carry_in");
    add_expect(16'h00E9, 8'hC2, "skc_clear");
    add_expect(16'h00EA, 8'hF0, "sui_borrow");
    add_expect(16'h00EC, 8'h00, "inr_wrap");
    add_expect(16'h00EE, 8'hC4, "inr_keeps_cy");
    add_expect(16'h00EF, 8'hFF, "dcr_wrap");
    add_expect(16'h00F0, 8'hC5, "dcr_clears_z");
    add_expect(16'h00F1, 8'h0C, "ani");
    add_expect(16'h00F2, 8'h5A, "ori");
    add_expect(16'h00F3, 8'h00, "xri_zero");
    add_expect(16'h00F4, 8'hC6, "sknz_on_zero");
    add_expect(16'h00F5, 8'h83, "daa_38_45");
    add_expect(16'h00F6, 8'h00, "daa_99_01");
    add_expect(16'h00F7, 8'hC7, "daa_carry");
    add_expect(16'h00F8, 8'hD0, "skip_mvi");
    add_expect(16'h00F9, 8'hD2, "jr_forward");
    add_expect(16'h00FA, 8'h01, "loop_pass_1");
    add_expect(16'h00FA, 8'h02, "loop_pass_2");
    add_expect(16'h00FA, 8'h03, "loop_pass_3");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Checks

  task automatic check_idle_bus();
    assert (m1 === 1'b0 && rdb === 1'b1 && wrb === 1'b1 && halted === 1'b0) else begin
      $display("error at %0t ns: bus not idle in reset (m1 %b rdb %b wrb %b halted %b)",
               $time, m1, rdb, wrb, halted);
      errors++;
    end
  endtask

  task automatic check_write(input logic [15:0] a, input logic [7:0] d);
    bit ok;
    if (next_idx >= exp_addr.size()) begin
      $display("A write of %h to %h came after the last expected store", d, a);
      errors++;
    end else begin
      ok = (a === exp_addr[next_idx]) && (d === exp_data[next_idx]);
      assert (ok) else begin
        $display("error at %0t ns: %s wrote %h to %h, expected %h to %h", $time,
                 exp_name[next_idx], d, a, exp_data[next_idx], exp_addr[next_idx]);
        errors++;
      end
      if (ok) begin
        passed++;
      end
      $display("store %0d %s %s", next_idx + 1, exp_name[next_idx], ok ? "ok" : "mismatch");
      next_idx++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence

  initial begin : main
    int unsigned idle_cycles;
    int          limit;
    int          cycles;
    int          low_run;
    bit          first_fetch;
    bit          done;
    bit          late;

    rst_n = 1'b0;
    build_table();
    void'($urandom(SEED));
    idle_cycles = $urandom % 4;
    limit = (exp_addr.size() * 12 + 256) * PHASES;

    repeat (RESET_LEN + idle_cycles) begin
      @(negedge CLK);
      check_idle_bus();
    end
    @(posedge CLK);
    #DRIVE_DELAY;
    rst_n = 1'b1;

    cycles      = 0;
    low_run     = 0;
    first_fetch = 1'b1;
    done        = 1'b0;
    while (!done) begin
      @(negedge CLK);
      cycles++;
      if (first_fetch && m1 === 1'b1) begin
        first_fetch = 1'b0;
        assert (addr === RESET_PC) else begin
          $display("error at %0t ns: first fetch from %h, expected %h", $time, addr, RESET_PC);
          errors++;
        end
      end
      // WRB is low for the cp1_fall and cp2_rise phases of a store only
      if (wrb !== 1'b1) begin
        low_run++;
      end else begin
        if (low_run != 0 && (low_run != 2 || UUT.cp2_fall !== 1'b1)) begin
          $display("The write strobe pulse did not match the cp1_fall and cp2_rise phases");
          errors++;
        end
        low_run = 0;
      end
      if (low_run > 2) begin
        $display("The write strobe stayed low without completing a write");
        errors++;
        done = 1'b1;
      end
      if (wrb === 1'b0 && UUT.cp2_rise === 1'b1) begin
        check_write(addr, dout);
      end
      if (halted === 1'b1) begin
        done = 1'b1;
      end else if (cycles >= limit) begin
        $display("Timeout, the program did not halt within %0d clock cycles", limit);
        errors++;
        done = 1'b1;
      end
    end

    if (halted === 1'b1) begin
      if (next_idx < exp_addr.size()) begin
        $display("Halted with %0d expected writes missing", exp_addr.size() - next_idx);
        errors++;
      end
      // Bus stays quiet once halted
      late = 1'b0;
      repeat (8 * PHASES) begin
        @(negedge CLK);
        if (wrb !== 1'b1) begin
          late = 1'b1;
        end
      end
      if (late) begin
        $display("The bus started a write after HALT");
        errors++;
      end
    end

    $display("Summary: %0d stores expected, %0d passed, %0d errors",
             exp_addr.size(), passed, errors);
    if (errors == 0 && passed == exp_addr.size()) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== program.mem ====
// Program image, one hex byte per value, loaded from address 00
// Each line holds opcode and operand bytes, then the start address and what they do
6A 11 6B 22 6C 33 6D 44                              // 00 MVI B, C, D, E
0A 6F E0 3B 0B 6F E1 3B 0C 6F E2 3B 0D 6F E3 3B      // 08 MOV A,r and STAX to E0..E3
6E 55 0E 6E 00 6F E4 3B 6F 66 0F 6F E5 3B            // 18 H and L through A to E4, E5
69 20 46 F0 6F E6 3B 69 C1 6F E7 48 3B               // 26 ADI with carry, SKC skips E7
69 05 56 10 6F E8 3B 69 C2 6F E9 48 3B               // 33 ACI uses carry, SKC falls through
69 10 66 20 6F EA 3B 69 C3 6F EB 48 3B               // 40 SUI borrows, SKC skips EB
69 FF 41 6F EC 3B 69 C4 6F ED 4A 3B 6F EE 49 3B      // 4D INR A wraps, SKZ skips, SKNC stores
6A 00 52 0A 6F EF 3B 69 C5 6F F0 4A 3B               // 5D DCR B wraps, SKZ falls through
69 3C 07 0F 6F F1 3B 69 50 17 0A 6F F2 3B            // 6A ANI and ORI
69 A5 16 A5 6F F3 3B 69 C6 6F F4 4B 3B               // 78 XRI to zero, SKNZ falls through
69 38 46 45 61 6F F5 3B                              // 85 DAA after 38 + 45
69 99 46 01 61 6F F6 3B 69 C7 6F F7 49 3B            // 8D DAA after 99 + 01, SKNC stores
69 D0 6F F8 48 3B 48 69 EE 3B                        // 9B SKC skips STAX, then MVI A,EE
69 D1 6F F9 C1 3B 69 D2 3B                           // A5 JR +1 over a STAX
69 00 6A 03 6F FA 41 3B 52 4A FB                     // AE loop of three, JR -5 to B4
01 69 EE 3B                                          // B9 HALT, then a store never reached

// ==== filelist.f ====
logic/upd78_pkg.sv
logic/phase_gen.sv
logic/upd78_regs.sv
logic/upd78_alu.sv
logic/upd78_core.sv
logic/bus_memory.sv
logic/upd78_system.sv
test/tb_upd78_system.sv

// ==== Bender.yml ====
package:
  name: upd78_system

sources:
  - logic/upd78_pkg.sv
  - logic/phase_gen.sv
  - logic/upd78_regs.sv
  - logic/upd78_alu.sv
  - logic/upd78_core.sv
  - logic/bus_memory.sv
  - logic/upd78_system.sv
  - target: test
    files:
      - test/tb_upd78_system.sv
